// ==== bench/hio_assertions.sv ====
/*
 * bridge protocol assertions
 * download write qualification, credit limit and PS/2 idle line
 */

`timescale 1ns/1ps

module hio_assertions (
	input logic clk_sys,
	input logic rst_n,
	input logic ioctl_wr,
	input logic ioctl_download,
	input logic dl_credit,
	input logic ps2_clk_out,
	input logic ps2_dat_out
);
	import hio_pkg::*;

	// writes not yet paid back by the consumer
	int outstanding;
	// cycles with clock high and data low
	int low_while_idle;
	// assertion failures seen so far
	int fail_cnt = 0;

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			outstanding    <= 0;
			low_while_idle <= 0;
		end else begin
			outstanding <= outstanding + int'(ioctl_wr) - int'(dl_credit);
			low_while_idle <= (ps2_clk_out && !ps2_dat_out) ? low_while_idle + 1 : 0;
		end
	end

	a_wr_in_download: assert property (@(posedge clk_sys) disable iff (!rst_n)
		ioctl_wr |-> ioctl_download)
		else begin
			fail_cnt++;
			$error("ioctl_wr outside a download");
		end

	a_credit_limit: assert property (@(posedge clk_sys) disable iff (!rst_n)
		outstanding <= DL_CREDITS)
		else begin
			fail_cnt++;
			$error("more writes than credits");
		end

	// inside a frame data stays low under a high clock for one half period at most
	a_ps2_idle_high: assert property (@(posedge clk_sys) disable iff (!rst_n)
		low_while_idle < 2 * PS2_DIV)
		else begin
			fail_cnt++;
			$error("PS/2 data low on an idle clock");
		end

endmodule

// ==== bench/hio_tb.sv ====
/*
 * host command bridge testbench
 * sends a table of host bursts to the bridge, returns download
 * credits late, rebuilds PS/2 frames and checks every result
 */

`timescale 1ns/1ps

module hio_tb;
	import hio_pkg::*;

	typedef struct {
		string       name;
		logic [7:0]  op;
		int          nw;
		logic [15:0] d [4];
		logic [31:0] exp;
		logic [5:0]  led;
	} row_t;

	logic                 clk_sys = 1'b0;
	logic                 rst_n = 1'b0;
	logic                 io_enable = 1'b0;
	logic                 io_strobe = 1'b0;
	logic [IO_W-1:0]      io_din = '0;
	logic [IO_W-1:0]      io_dout;
	logic                 io_wait;
	logic [2:0]           kbd_led_status = 3'd0;
	logic [2:0]           kbd_led_use = 3'd0;
	logic [1:0]           buttons;
	logic                 forced_scandoubler;
	logic [IO_W-1:0]      joystick_0;
	logic [IO_W-1:0]      joystick_1;
	logic [31:0]          status;
	logic                 status_changed;
	logic                 ps2_clk_out;
	logic                 ps2_dat_out;
	logic                 ioctl_download;
	logic [7:0]           ioctl_index;
	logic [DL_ADDR_W-1:0] ioctl_addr;
	logic [7:0]           ioctl_dout;
	logic                 ioctl_wr;
	logic                 dl_credit = 1'b0;

	row_t                 rows [$];
	logic [31:0]          lfsr = 32'h6df0_ca0d;
	logic [7:0]           dl_bytes [10];
	int                   dl_delay [10];
	logic [IO_W-1:0]      led_dout;
	int                   change_cnt = 0;
	int                   wr_seen = 0;
	int                   cred_given = 0;
	int                   cred_wait = 0;
	bit                   wait_seen = 1'b0;
	logic [DL_ADDR_W-1:0] got_addr [$];
	logic [7:0]           got_byte [$];
	logic [10:0]          frame_sr = '0;
	int                   frame_bits = 0;
	logic [10:0]          frames [$];

	hio_top u_dut (.*);

	bind hio_top hio_assertions u_assertions (.*);

	always #10 clk_sys = ~clk_sys;

	////////////////////////////////
	// random source
	// galois form stepped once per bit taken
	function automatic logic [31:0] lfsr_next(logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
	endfunction

	task automatic take_bits(input int n, output logic [31:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_next(lfsr);
			v = {v[30:0], lfsr[0]};
		end
	endtask

	////////////////////////////////
	// checks
	task automatic check_word(string name, logic [15:0] exp, logic [15:0] act);
		if (act !== exp) begin
			$display("ERROR %s expected %h actual %h", name, exp, act);
			$display("RESULT: FAIL");
			$fatal(1);
		end
	endtask

	task automatic check_status(string name, logic [31:0] exp, logic [31:0] act);
		if (act !== exp) begin
			$display("ERROR %s expected %h actual %h", name, exp, act);
			$display("RESULT: FAIL");
			$fatal(1);
		end
	endtask

	task automatic check_byte(string name, logic [7:0] exp, logic [7:0] act);
		if (act !== exp) begin
			$display("ERROR %s expected %h actual %h", name, exp, act);
			$display("RESULT: FAIL");
			$fatal(1);
		end
	endtask

	task automatic check_addr(string name, logic [DL_ADDR_W-1:0] exp,
		logic [DL_ADDR_W-1:0] act);
		if (act !== exp) begin
			$display("ERROR %s expected %h actual %h", name, exp, act);
			$display("RESULT: FAIL");
			$fatal(1);
		end
	endtask

	task automatic stop_on(string what);
		$display("%s", what);
		$display("RESULT: FAIL");
		$fatal(1);
	endtask

	////////////////////////////////
	// consumer sink and monitors
	always @(posedge clk_sys) begin
		if (status_changed)
			change_cnt <= change_cnt + 1;
		if (ioctl_wr) begin
			wr_seen <= wr_seen + 1;
			got_addr.push_back(ioctl_addr);
			got_byte.push_back(ioctl_dout);
		end
	end

	// one credit at a time with its own delay each
	always @(negedge clk_sys) begin
		dl_credit <= 1'b0;
		if (wr_seen > cred_given) begin
			if (cred_wait >= dl_delay[cred_given % 10]) begin
				dl_credit  <= 1'b1;
				cred_given <= cred_given + 1;
				cred_wait  <= 0;
			end else begin
				cred_wait <= cred_wait + 1;
			end
		end
	end

	// device clocks data on the falling PS/2 clock
	always @(negedge ps2_clk_out) begin
		if (rst_n) begin
			frame_sr[frame_bits] = ps2_dat_out;
			frame_bits++;
			if (frame_bits == 11) begin
				frames.push_back(frame_sr);
				frame_bits = 0;
			end
		end
	end

	////////////////////////////////
	// host side
	task automatic strobe_word(logic [15:0] w);
		io_din    = w;
		io_strobe = 1'b1;
		@(negedge clk_sys);
		io_strobe = 1'b0;
	endtask

	task automatic send_row(row_t r);
		io_word_u cmd;
		int       t;
		cmd.cmd.rsvd   = 8'h00;
		cmd.cmd.opcode = r.op;
		io_enable = 1'b1;
		@(negedge clk_sys);
		strobe_word(cmd.raw);
		@(negedge clk_sys);
		for (int i = 0; i < r.nw; i++) begin
			if (r.op == OP_FILE_DAT) begin
				t = 0;
				while (io_wait) begin
					wait_seen = 1'b1;
					@(negedge clk_sys);
					t++;
					if (t > 200)
						stop_on("io_wait never dropped during download");
				end
				strobe_word({8'h00, dl_bytes[i]});
			end else begin
				strobe_word(r.d[i]);
			end
			if (i == 0)
				led_dout = io_dout;
			@(negedge clk_sys);
		end
		io_enable = 1'b0;
		repeat (2) @(negedge clk_sys);
	endtask

	// LED i has use at bit 2i and status at bit 2i+1
	function automatic logic [15:0] led_expect(logic [5:0] led);
		logic [15:0] w;
		w = 16'h0040;
		for (int i = 0; i < 3; i++) begin
			w[2*i]   = led[i];
			w[2*i+1] = led[3+i];
		end
		return w;
	endfunction

	task automatic check_row(row_t r, int changes_before);
		int          t;
		logic [10:0] f;
		logic [10:0] ef;
		case (r.op)
			OP_CFG: check_word(r.name, {13'd0, r.d[0][4], r.d[0][1:0]},
				{13'd0, forced_scandoubler, buttons});
			OP_JOY0: check_word(r.name, r.d[0], joystick_0);
			OP_JOY1: check_word(r.name, r.d[0], joystick_1);
			OP_STATUS: begin
				check_status(r.name, {r.d[1], r.d[0]}, status);
				check_word({r.name, " pulses"}, r.exp[15:0],
					16'(change_cnt - changes_before));
			end
			OP_LED_RD: check_word(r.name, led_expect(r.led), led_dout);
			OP_KBD: begin
				t = 0;
				while (frames.size() < r.nw) begin
					@(negedge clk_sys);
					t++;
					if (t > 4000)
						stop_on("PS/2 frames did not all arrive");
				end
				for (int i = 0; i < r.nw; i++) begin
					f  = frames.pop_front();
					ef = {1'b1, ~^r.d[i][7:0], r.d[i][7:0], 1'b0};
					check_byte({r.name, " data"}, r.d[i][7:0], f[8:1]);
					check_word({r.name, " frame"}, {5'd0, ef}, {5'd0, f});
				end
			end
			OP_FILE_IDX: check_byte(r.name, r.d[0][7:0], ioctl_index);
			OP_FILE_TX: check_word(r.name, {15'd0, |r.d[0][7:0]},
				{15'd0, ioctl_download});
			OP_FILE_DAT: begin
				t = 0;
				while (got_byte.size() < r.nw || cred_given < wr_seen) begin
					@(negedge clk_sys);
					t++;
					if (t > 1000)
						stop_on("download writes or credits went missing");
				end
				if (!wait_seen)
					stop_on("io_wait never held the host off");
				for (int i = 0; i < r.nw; i++) begin
					check_addr({r.name, " addr"}, DL_ADDR_W'(i), got_addr[i]);
					check_byte({r.name, " byte"}, dl_bytes[i], got_byte[i]);
				end
			end
			default: ;
		endcase
		check_word({r.name, " idle dout"}, 16'h0000, io_dout);
	endtask

	task automatic add_row(string name, logic [7:0] op, int nw, logic [15:0] d0,
		logic [15:0] d1, logic [15:0] d2, logic [31:0] exp, logic [5:0] led);
		row_t r;
		r.name = name;
		r.op   = op;
		r.nw   = nw;
		r.d[0] = d0;
		r.d[1] = d1;
		r.d[2] = d2;
		r.d[3] = 16'h0000;
		r.exp  = exp;
		r.led  = led;
		rows.push_back(r);
	endtask

	initial begin
		logic [31:0] v;
		int          c;
		for (int i = 0; i < 10; i++) begin
			take_bits(8, v);
			dl_bytes[i] = v[7:0];
			take_bits(3, v);
			dl_delay[i] = 2 + int'(v[2:0]);
		end
		add_row("cfg", OP_CFG, 1, 16'h0012, 0, 0, 0, 0);
		add_row("joy0", OP_JOY0, 1, 16'hA55A, 0, 0, 0, 0);
		add_row("joy1", OP_JOY1, 1, 16'h0F3C, 0, 0, 0, 0);
		add_row("status new", OP_STATUS, 2, 16'h5678, 16'h1234, 0, 1, 0);
		add_row("status same", OP_STATUS, 2, 16'h5678, 16'h1234, 0, 0, 0);
		add_row("led read", OP_LED_RD, 1, 16'h0000, 0, 0, 0, 6'b101_011);
		add_row("kbd", OP_KBD, 3, 16'h001C, 16'h00F0, 16'h0081, 0, 0);
		add_row("dl index", OP_FILE_IDX, 1, 16'h0042, 0, 0, 0, 0);
		add_row("dl start", OP_FILE_TX, 1, 16'h00FF, 0, 0, 0, 0);
		add_row("dl data", OP_FILE_DAT, 10, 0, 0, 0, 0, 0);
		add_row("dl end", OP_FILE_TX, 1, 16'h0000, 0, 0, 0, 0);

		repeat (4) @(posedge clk_sys);
		@(negedge clk_sys);
		rst_n = 1'b1;
		@(negedge clk_sys);
		check_word("reset outputs", 16'h0003,
			{10'd0, ioctl_wr, ioctl_download, io_wait, status_changed,
			ps2_clk_out, ps2_dat_out});

		foreach (rows[i]) begin
			kbd_led_status = rows[i].led[5:3];
			kbd_led_use    = rows[i].led[2:0];
			c = change_cnt;
			send_row(rows[i]);
			check_row(rows[i], c);
		end
		if (u_dut.u_assertions.fail_cnt != 0) begin
			stop_on("protocol assertions failed during the run");
		end else begin
			$display("RESULT: PASS");
			$finish;
		end
	end

endmodule

// ==== filelist.f ====
hdl/hio_pkg.sv
hdl/hio_cmd_decoder.sv
hdl/hio_cfg_regs.sv
hdl/ps2_kbd_device.sv
hdl/file_download.sv
hdl/hio_top.sv
bench/hio_assertions.sv
bench/hio_tb.sv

// ==== hdl/file_download.sv ====
/*
 * file download unit
 * holds the download index and active flag, steps the write address
 * and emits one byte write per host data word,
 * a credit counter holds the host off when the consumer is full
 */

`timescale 1ns/1ps

module file_download (
	input  logic                          clk_sys,
	input  logic                          rst_n,
	input  logic                          dl_idx_we,
	input  logic                          dl_ctrl_we,
	input  logic                          dl_dat_we,
	input  logic [hio_pkg::IO_W-1:0]      reg_data,
	input  logic                          dl_credit,
	output logic                          io_wait,
	output logic                          ioctl_download,
	output logic [7:0]                    ioctl_index,
	output logic [hio_pkg::DL_ADDR_W-1:0] ioctl_addr,
	output logic                          ioctl_wr,
	output logic [7:0]                    ioctl_dout
);
	import hio_pkg::*;

	logic [DL_ADDR_W-1:0] addr;
	logic [CREDIT_W-1:0]  credits;

	////////////////////////////////
	// write port payload
	always_ff @(posedge clk_sys) begin
		if (dl_idx_we)
			ioctl_index <= reg_data[7:0];
		if (dl_dat_we) begin
			ioctl_addr <= addr;
			ioctl_dout <= reg_data[7:0];
		end
	end

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			ioctl_download <= 1'b0;
			ioctl_wr       <= 1'b0;
			addr           <= '0;
		end else begin
			ioctl_wr <= dl_dat_we;
			if (dl_ctrl_we) begin
				// nonzero starts from address 0, zero ends
				ioctl_download <= |reg_data[7:0];
				if (|reg_data[7:0])
					addr <= '0;
			end
			if (dl_dat_we)
				addr <= addr + 1'b1;
		end
	end

	////////////////////////////////
	// credits, one per write, back on dl_credit
	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			credits <= CREDIT_W'(DL_CREDITS);
		end else if (ioctl_wr && !dl_credit) begin
			if (credits != '0)
				credits <= credits - 1'b1;
		end else if (dl_credit && !ioctl_wr) begin
			if (credits != CREDIT_W'(DL_CREDITS))
				credits <= credits + 1'b1;
		end
	end

	assign io_wait = (credits == '0);

endmodule

// ==== hdl/hio_cfg_regs.sv ====
/*
 * configuration register block
 * config byte, two joystick words and the 32-bit status word
 * committed in one step when its high half arrives,
 * plus the keyboard LED word read by the host
 */

`timescale 1ns/1ps

module hio_cfg_regs (
	input  logic                     clk_sys,
	input  logic                     rst_n,
	input  logic                     cfg_we,
	input  logic                     joy0_we,
	input  logic                     joy1_we,
	input  logic                     status_lo_we,
	input  logic                     status_hi_we,
	input  logic [hio_pkg::IO_W-1:0] reg_data,
	input  logic [2:0]               kbd_led_status,
	input  logic [2:0]               kbd_led_use,
	output logic [1:0]               buttons,
	output logic                     forced_scandoubler,
	output logic [hio_pkg::IO_W-1:0] joystick_0,
	output logic [hio_pkg::IO_W-1:0] joystick_1,
	output logic [31:0]              status,
	output logic                     status_changed,
	output logic [hio_pkg::IO_W-1:0] led_word
);

	logic [7:0]  cfg;
	logic [15:0] status_lo;
	logic [31:0] status_new;

	// bits 3:2 and 5 are used elsewhere in the system
	assign buttons            = cfg[1:0];
	assign forced_scandoubler = cfg[4];

	assign status_new = {reg_data, status_lo};

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			cfg            <= 8'h00;
			joystick_0     <= '0;
			joystick_1     <= '0;
			status_lo      <= 16'h0000;
			status         <= 32'h0000_0000;
			status_changed <= 1'b0;
		end else begin
			status_changed <= 1'b0;
			if (cfg_we)
				cfg <= reg_data[7:0];
			if (joy0_we)
				joystick_0 <= reg_data;
			if (joy1_we)
				joystick_1 <= reg_data;
			// stage low half, nothing visible yet
			if (status_lo_we)
				status_lo <= reg_data;
			if (status_hi_we) begin
				status         <= status_new;
				status_changed <= (status_new != status);
			end
		end
	end

	// per LED: use below, status above, bit 6 marks the word valid
	assign led_word = {9'd0, 1'b1,
		kbd_led_status[2], kbd_led_use[2],
		kbd_led_status[1], kbd_led_use[1],
		kbd_led_status[0], kbd_led_use[0]};

endmodule

// ==== hdl/hio_cmd_decoder.sv ====
/*
 * host bus command decoder
 * follows the command/data phase of each enable burst, latches the
 * opcode from the first strobe and turns every later strobe into a
 * single write pulse, registers the LED word read back to the host
 */

`timescale 1ns/1ps

module hio_cmd_decoder (
	input  logic                        clk_sys,
	input  logic                        rst_n,
	input  logic                        io_enable,
	input  logic                        io_strobe,
	input  hio_pkg::io_word_u           io_din,
	input  logic [hio_pkg::IO_W-1:0]    led_word,
	output logic [hio_pkg::IO_W-1:0]    io_dout,
	output logic                        cfg_we,
	output logic                        joy0_we,
	output logic                        joy1_we,
	output logic                        status_lo_we,
	output logic                        status_hi_we,
	output logic                        kbd_we,
	output logic [7:0]                  kbd_data,
	output logic                        dl_idx_we,
	output logic                        dl_ctrl_we,
	output logic                        dl_dat_we,
	output logic [hio_pkg::IO_W-1:0]    reg_data
);
	import hio_pkg::*;

	// word number inside the burst, 0 is the command
	logic [1:0] word_cnt;
	logic [7:0] opcode;
	logic       data_stb;
	logic       led_rd;

	assign data_stb = io_enable & io_strobe & (word_cnt != 2'd0);

	// payload goes straight through, strobes qualify it
	assign reg_data = io_din.raw;
	assign kbd_data = io_din.raw[7:0];

	////////////////////////////////
	// phase tracking
	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			word_cnt <= 2'd0;
			opcode   <= 8'h00;
		end else if (!io_enable) begin
			// enable low ends the command
			word_cnt <= 2'd0;
			opcode   <= 8'h00;
		end else if (io_strobe) begin
			if (word_cnt == 2'd0)
				opcode <= io_din.cmd.opcode;
			// saturate, only words 1 and 2 are told apart
			if (word_cnt != 2'd3)
				word_cnt <= word_cnt + 2'd1;
		end
	end

	////////////////////////////////
	// opcode to strobe decode
	always_comb begin
		cfg_we       = 1'b0;
		joy0_we      = 1'b0;
		joy1_we      = 1'b0;
		status_lo_we = 1'b0;
		status_hi_we = 1'b0;
		kbd_we       = 1'b0;
		dl_idx_we    = 1'b0;
		dl_ctrl_we   = 1'b0;
		dl_dat_we    = 1'b0;
		led_rd       = 1'b0;
		if (data_stb) begin
			case (opcode)
				OP_CFG:      cfg_we  = 1'b1;
				OP_JOY0:     joy0_we = 1'b1;
				OP_JOY1:     joy1_we = 1'b1;
				OP_KBD:      kbd_we  = 1'b1;
				// low half first, high half commits
				OP_STATUS: begin
					status_lo_we = (word_cnt == 2'd1);
					status_hi_we = (word_cnt == 2'd2);
				end
				OP_LED_RD:   led_rd     = (word_cnt == 2'd1);
				OP_FILE_TX:  dl_ctrl_we = 1'b1;
				OP_FILE_DAT: dl_dat_we  = 1'b1;
				OP_FILE_IDX: dl_idx_we  = 1'b1;
				default: ;
			endcase
		end
	end

	// read data for one cycle, zero otherwise
	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n)
			io_dout <= '0;
		else
			io_dout <= led_rd ? led_word : '0;
	end

endmodule

// ==== hdl/hio_pkg.sv ====
/*
 * host command bridge shared definitions
 * opcodes of the host strobe bus, bus and download sizes,
 * PS/2 keyboard sizing and the host word decode union
 */

package hio_pkg;

	////////////////////////////////
	// sizes
	localparam int IO_W           = 16;
	localparam int DL_ADDR_W      = 25;
	// consumer buffer depth, bridge starts with this many credits
	localparam int DL_CREDITS     = 4;
	localparam int CREDIT_W       = $clog2(DL_CREDITS + 1);
	localparam int PS2_FIFO_DEPTH = 16;
	localparam int PS2_PTR_W      = $clog2(PS2_FIFO_DEPTH);
	// sys clocks per PS/2 half period, kept short for simulation
	localparam int PS2_DIV        = 8;
	localparam int PS2_DIV_W      = $clog2(PS2_DIV);

	////////////////////////////////
	// host opcodes
	localparam logic [7:0] OP_CFG      = 8'h01;
	localparam logic [7:0] OP_JOY0     = 8'h02;
	localparam logic [7:0] OP_JOY1     = 8'h03;
	localparam logic [7:0] OP_KBD      = 8'h05;
	localparam logic [7:0] OP_STATUS   = 8'h1E;
	localparam logic [7:0] OP_LED_RD   = 8'h1F;
	localparam logic [7:0] OP_FILE_TX  = 8'h53;
	localparam logic [7:0] OP_FILE_DAT = 8'h54;
	localparam logic [7:0] OP_FILE_IDX = 8'h55;

	// first word of a burst
	typedef struct packed {
		logic [7:0] rsvd;
		logic [7:0] opcode;
	} io_cmd_t;

	// one host word, read as command or as data depending on phase
	typedef union packed {
		io_cmd_t         cmd;
		logic [IO_W-1:0] raw;
	} io_word_u;

endpackage

// ==== hdl/hio_top.sv ====
/*
 * host command bridge top level
 * decoder, register block, PS/2 keyboard and download unit
 */

`timescale 1ns/1ps

module hio_top (
	input  logic                          clk_sys,
	input  logic                          rst_n,
	// host strobe bus
	input  logic                          io_enable,
	input  logic                          io_strobe,
	input  logic [hio_pkg::IO_W-1:0]      io_din,
	output logic [hio_pkg::IO_W-1:0]      io_dout,
	output logic                          io_wait,
	// core side
	input  logic [2:0]                    kbd_led_status,
	input  logic [2:0]                    kbd_led_use,
	output logic [1:0]                    buttons,
	output logic                          forced_scandoubler,
	output logic [hio_pkg::IO_W-1:0]      joystick_0,
	output logic [hio_pkg::IO_W-1:0]      joystick_1,
	output logic [31:0]                   status,
	output logic                          status_changed,
	output logic                          ps2_clk_out,
	output logic                          ps2_dat_out,
	// download port
	output logic                          ioctl_download,
	output logic [7:0]                    ioctl_index,
	output logic [hio_pkg::DL_ADDR_W-1:0] ioctl_addr,
	output logic [7:0]                    ioctl_dout,
	output logic                          ioctl_wr,
	input  logic                          dl_credit
);
	import hio_pkg::*;

	logic            cfg_we;
	logic            joy0_we;
	logic            joy1_we;
	logic            status_lo_we;
	logic            status_hi_we;
	logic            kbd_we;
	logic [7:0]      kbd_data;
	logic            dl_idx_we;
	logic            dl_ctrl_we;
	logic            dl_dat_we;
	logic [IO_W-1:0] reg_data;
	logic [IO_W-1:0] led_word;

	hio_cmd_decoder u_decoder (
		.clk_sys      (clk_sys),
		.rst_n        (rst_n),
		.io_enable    (io_enable),
		.io_strobe    (io_strobe),
		.io_din       (io_din),
		.led_word     (led_word),
		.io_dout      (io_dout),
		.cfg_we       (cfg_we),
		.joy0_we      (joy0_we),
		.joy1_we      (joy1_we),
		.status_lo_we (status_lo_we),
		.status_hi_we (status_hi_we),
		.kbd_we       (kbd_we),
		.kbd_data     (kbd_data),
		.dl_idx_we    (dl_idx_we),
		.dl_ctrl_we   (dl_ctrl_we),
		.dl_dat_we    (dl_dat_we),
		.reg_data     (reg_data)
	);

	hio_cfg_regs u_regs (
		.clk_sys            (clk_sys),
		.rst_n              (rst_n),
		.cfg_we             (cfg_we),
		.joy0_we            (joy0_we),
		.joy1_we            (joy1_we),
		.status_lo_we       (status_lo_we),
		.status_hi_we       (status_hi_we),
		.reg_data           (reg_data),
		.kbd_led_status     (kbd_led_status),
		.kbd_led_use        (kbd_led_use),
		.buttons            (buttons),
		.forced_scandoubler (forced_scandoubler),
		.joystick_0         (joystick_0),
		.joystick_1         (joystick_1),
		.status             (status),
		.status_changed     (status_changed),
		.led_word           (led_word)
	);

	ps2_kbd_device u_kbd (
		.clk_sys     (clk_sys),
		.rst_n       (rst_n),
		.kbd_we      (kbd_we),
		.kbd_data    (kbd_data),
		.ps2_clk_out (ps2_clk_out),
		.ps2_dat_out (ps2_dat_out)
	);

	file_download u_download (
		.clk_sys        (clk_sys),
		.rst_n          (rst_n),
		.dl_idx_we      (dl_idx_we),
		.dl_ctrl_we     (dl_ctrl_we),
		.dl_dat_we      (dl_dat_we),
		.reg_data       (reg_data),
		.dl_credit      (dl_credit),
		.io_wait        (io_wait),
		.ioctl_download (ioctl_download),
		.ioctl_index    (ioctl_index),
		.ioctl_addr     (ioctl_addr),
		.ioctl_wr       (ioctl_wr),
		.ioctl_dout     (ioctl_dout)
	);

endmodule

// ==== hdl/ps2_kbd_device.sv ====
/*
 * PS/2 keyboard device side
 * queues host bytes in a small FIFO and sends each one as an
 * 11-bit device-to-host frame on a locally divided PS/2 clock
 */

`timescale 1ns/1ps

module ps2_kbd_device (
	input  logic       clk_sys,
	input  logic       rst_n,
	input  logic       kbd_we,
	input  logic [7:0] kbd_data,
	output logic       ps2_clk_out,
	output logic       ps2_dat_out
);
	import hio_pkg::*;

	logic [7:0]           fifo_mem [PS2_FIFO_DEPTH];
	// extra top bit tells full from empty
	logic [PS2_PTR_W:0]   wptr;
	logic [PS2_PTR_W:0]   rptr;
	logic                 fifo_empty;
	logic                 fifo_full;
	logic [PS2_DIV_W-1:0] div_cnt;
	logic                 clk_div;
	logic                 div_tick;
	logic                 div_rise;
	logic                 div_fall;
	logic [3:0]           tx_state;
	logic [7:0]           tx_byte;
	logic                 parity;
	logic                 tx_load;

	assign fifo_empty = (wptr == rptr);
	assign fifo_full  = (wptr[PS2_PTR_W] != rptr[PS2_PTR_W]) &&
		(wptr[PS2_PTR_W-1:0] == rptr[PS2_PTR_W-1:0]);

	////////////////////////////////
	// byte FIFO
	always_ff @(posedge clk_sys) begin
		if (kbd_we && !fifo_full)
			fifo_mem[wptr[PS2_PTR_W-1:0]] <= kbd_data;
	end

	// bytes arriving while full are lost
	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n)
			wptr <= '0;
		else if (kbd_we && !fifo_full)
			wptr <= wptr + 1'b1;
	end

	////////////////////////////////
	// PS/2 clock divider
	assign div_tick = (div_cnt == PS2_DIV_W'(PS2_DIV - 1));
	assign div_rise = div_tick & ~clk_div;
	assign div_fall = div_tick & clk_div;

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			div_cnt <= '0;
			clk_div <= 1'b1;
		end else if (div_tick) begin
			div_cnt <= '0;
			clk_div <= ~clk_div;
		end else begin
			div_cnt <= div_cnt + 1'b1;
		end
	end

	////////////////////////////////
	// frame transmitter
	// state 0 idle, 1..8 data, 9 parity, 10 stop, 11 last low phase
	assign tx_load = div_rise && (tx_state == 4'd0) && !fifo_empty;

	// shift register only meaningful once loaded
	always_ff @(posedge clk_sys) begin
		if (tx_load)
			tx_byte <= fifo_mem[rptr[PS2_PTR_W-1:0]];
		else if (div_rise && tx_state >= 4'd1 && tx_state <= 4'd8)
			tx_byte <= {1'b0, tx_byte[7:1]};
	end

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			rptr        <= '0;
			tx_state    <= 4'd0;
			parity      <= 1'b1;
			ps2_dat_out <= 1'b1;
			ps2_clk_out <= 1'b1;
		end else begin
			if (tx_load) begin
				rptr        <= rptr + 1'b1;
				parity      <= 1'b1;
				tx_state    <= 4'd1;
				// start bit
				ps2_dat_out <= 1'b0;
			end else if (div_rise && tx_state != 4'd0) begin
				if (tx_state <= 4'd8) begin
					// lsb first, parity counts the ones
					ps2_dat_out <= tx_byte[0];
					parity      <= parity ^ tx_byte[0];
				end else if (tx_state == 4'd9) begin
					ps2_dat_out <= parity;
				end else begin
					ps2_dat_out <= 1'b1;
				end
				tx_state <= (tx_state == 4'd11) ? 4'd0 : tx_state + 4'd1;
			end
			// clock low phases only shown while a frame is out
			if (div_rise)
				ps2_clk_out <= 1'b1;
			else if (div_fall)
				ps2_clk_out <= (tx_state == 4'd0);
		end
	end

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# build and run the bridge testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module hio_tb -f filelist.f -o hio_sim
if [ $? -ne 0 ]; then
	echo "build failed"
	exit 1
fi

out=$(./obj_dir/hio_sim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if echo "$out" | grep -q "RESULT: PASS"; then
	exit 0
fi
exit 1
